/* fault_capture.f */
+incdir+rtl
rtl/fault_bus_pkg.sv
rtl/fault_code_pkg.sv
rtl/fault_bus_if.sv
rtl/sticky_reg.sv
rtl/seq_checker.sv
rtl/fault_bank.sv
rtl/fault_capture_top.sv
tb/tb_fault_capture.sv

/* rtl/fault_bank.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fault_defs.svh"

module fault_bank
    import fault_bus_pkg::*;
    import fault_code_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    fault_bus_if.target bus,
    input  logic        seq_err,
    input  fault_rec_t  seq_rec,
    input  logic        par_err,
    input  fault_rec_t  par_rec,
    input  logic        ext_err,
    input  fault_rec_t  ext_rec,
    output bus_data_t   rdat,
    output logic        rvld,
    output logic        irq
);

    // Per-register returns
    bus_data_t  seq_rdat;
    bus_data_t  par_rdat;
    bus_data_t  ext_rdat;
    bus_data_t  stat_rdat;
    logic       seq_rvld;
    logic       par_rvld;
    logic       ext_rvld;
    logic       stat_rvld;

    // Bit 0 seq, bit 1 parity, bit 2 external
    logic [2:0] held;

    //////////////////////////////////////////////////
    // Sticky registers
    //////////////////////////////////////////////////

    sticky_reg #(.REG_ADDR(`FLT_ADDR_SEQ)) seq_reg0 (
        .clk  (clk),
        .rst  (rst),
        .idat (seq_rec),
        .ienb (seq_err),
        .bus  (bus),
        .rdat (seq_rdat),
        .rvld (seq_rvld),
        .held (held[0])
    );

    sticky_reg #(.REG_ADDR(`FLT_ADDR_PAR)) par_reg0 (
        .clk  (clk),
        .rst  (rst),
        .idat (par_rec),
        .ienb (par_err),
        .bus  (bus),
        .rdat (par_rdat),
        .rvld (par_rvld),
        .held (held[1])
    );

    sticky_reg #(.REG_ADDR(`FLT_ADDR_EXT)) ext_reg0 (
        .clk  (clk),
        .rst  (rst),
        .idat (ext_rec),
        .ienb (ext_err),
        .bus  (bus),
        .rdat (ext_rdat),
        .rvld (ext_rvld),
        .held (held[2])
    );

    //////////////////////////////////////////////////
    // Status, read merge, interrupt
    //////////////////////////////////////////////////

    // Read-only view of the held bits
    assign stat_rvld = bus.rden && (bus.addr == `FLT_ADDR_STAT);
    assign stat_rdat = stat_rvld ? {{(`FLT_DATA_W-3){1'b0}}, held} : '0;

    // Unselected sources return zero, so OR is safe
    assign rdat = seq_rdat | par_rdat | ext_rdat | stat_rdat;
    assign rvld = seq_rvld | par_rvld | ext_rvld | stat_rvld;

    // No masking
    assign irq = |held;

endmodule

`default_nettype wire

/* rtl/fault_bus_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface fault_bus_if
    import fault_bus_pkg::*;
();

    // Request side only, read data returns on plain ports
    bus_addr_t addr;
    logic      wren;
    bus_data_t wdat;
    logic      rden;

    // Bus driver at the top level
    modport master (
        output addr, wren, wdat, rden
    );

    // Registers decoding the request
    modport target (
        input addr, wren, wdat, rden
    );

endinterface

`default_nettype wire

/* rtl/fault_bus_pkg.sv */
`default_nettype none

`include "fault_defs.svh"

package fault_bus_pkg;

    // One bus address word
    typedef logic [`FLT_ADDR_W-1:0] bus_addr_t;

    // One bus data word, read and write
    typedef logic [`FLT_DATA_W-1:0] bus_data_t;

endpackage

`default_nettype wire

/* rtl/fault_capture_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fault_capture_top
    import fault_bus_pkg::*;
    import fault_code_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       s_valid,
    input  seq_num_t   s_seq,
    input  payload_t   s_data,
    input  logic       s_par,
    input  logic       ext_err,
    input  fault_rec_t ext_rec,
    input  bus_addr_t  ps_addr,
    input  logic       ps_wren,
    input  bus_data_t  ps_wdat,
    input  logic       ps_rden,
    output bus_data_t  ps_rdat,
    output logic       ps_rvld,
    output logic       irq
);

    logic       seq_err;
    logic       par_err;
    fault_rec_t seq_rec;
    fault_rec_t par_rec;

    //////////////////////////////////////////////////
    // Bus request into the interface
    //////////////////////////////////////////////////

    fault_bus_if bus0 ();

    assign bus0.addr = ps_addr;
    assign bus0.wren = ps_wren;
    assign bus0.wdat = ps_wdat;
    assign bus0.rden = ps_rden;

    //////////////////////////////////////////////////
    // Checker and register bank
    //////////////////////////////////////////////////

    // Stream observer, one cycle to the strobes
    seq_checker chk0 (
        .clk     (clk),
        .rst     (rst),
        .s_valid (s_valid),
        .s_seq   (s_seq),
        .s_data  (s_data),
        .s_par   (s_par),
        .seq_err (seq_err),
        .seq_rec (seq_rec),
        .par_err (par_err),
        .par_rec (par_rec)
    );

    fault_bank bank0 (
        .clk     (clk),
        .rst     (rst),
        .bus     (bus0.target),
        .seq_err (seq_err),
        .seq_rec (seq_rec),
        .par_err (par_err),
        .par_rec (par_rec),
        .ext_err (ext_err),
        .ext_rec (ext_rec),
        .rdat    (ps_rdat),
        .rvld    (ps_rvld),
        .irq     (irq)
    );

endmodule

`default_nettype wire

/* rtl/fault_code_pkg.sv */
`default_nettype none

`include "fault_defs.svh"

package fault_code_pkg;

    //////////////////////////////////////////////////
    // Stream side
    //////////////////////////////////////////////////

    typedef logic [`FLT_SEQ_W-1:0] seq_num_t;
    typedef logic [`FLT_SEQ_W-1:0] payload_t;

    // Captured record
    // Seq fault holds expected/received, parity fault holds seq/payload
    typedef logic [`FLT_DATA_W-1:0] fault_rec_t;

    //////////////////////////////////////////////////
    // Checker FSM
    //////////////////////////////////////////////////

    typedef enum logic [0:0] {
        SEQ_HUNT  = 1'b0,
        SEQ_TRACK = 1'b1
    } seq_state_t;

endpackage

`default_nettype wire

/* rtl/fault_defs.svh */
`ifndef FAULT_DEFS_SVH
`define FAULT_DEFS_SVH

//////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////

// Bus data and captured records
`define FLT_DATA_W 32
// Peripheral bus address
`define FLT_ADDR_W 8
// Sequence number, payload uses the same width
`define FLT_SEQ_W 16

//////////////////////////////////////////////////
// Register map
//////////////////////////////////////////////////

// Write value that releases a held register
`define FLT_CLR_CODE 32'h0000_0001

`define FLT_ADDR_SEQ 8'h00
`define FLT_ADDR_PAR 8'h04
`define FLT_ADDR_EXT 8'h08
`define FLT_ADDR_STAT 8'h0C

`endif

/* rtl/seq_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module seq_checker
    import fault_code_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       s_valid,
    input  seq_num_t   s_seq,
    input  payload_t   s_data,
    input  logic       s_par,
    output logic       seq_err,
    output fault_rec_t seq_rec,
    output logic       par_err,
    output fault_rec_t par_rec
);

    seq_state_t state;
    seq_num_t   exp_seq;
    logic       par_bad;
    logic       gap;

    //////////////////////////////////////////////////
    // Word checks
    //////////////////////////////////////////////////

    // Even parity over seq, payload and parity bit
    assign par_bad = ^{s_seq, s_data, s_par};

    // Gap only meaningful once locked to the stream
    assign gap = (state == SEQ_TRACK) && (s_seq != exp_seq);

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////

    // Any valid word locks the checker
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEQ_HUNT;
        end else if (s_valid) begin
            state <= SEQ_TRACK;
        end
    end

    // Next expected number
    // Same rule for in-order words and resync after a gap
    // Wraps at max
    always_ff @(posedge clk) begin
        if (s_valid) begin
            exp_seq <= s_seq + seq_num_t'(1);
        end
    end

    //////////////////////////////////////////////////
    // Fault strobes
    //////////////////////////////////////////////////

    // Registered and high for one cycle after the bad word
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_err <= 1'b0;
            par_err <= 1'b0;
        end else begin
            seq_err <= s_valid && gap;
            par_err <= s_valid && par_bad;
        end
    end

    // Records only load together with their strobe
    always_ff @(posedge clk) begin
        if (s_valid && gap) begin
            seq_rec <= {exp_seq, s_seq};
        end
        if (s_valid && par_bad) begin
            par_rec <= {s_seq, s_data};
        end
    end

endmodule

`default_nettype wire

/* rtl/sticky_reg.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fault_defs.svh"

module sticky_reg
    import fault_bus_pkg::*;
    import fault_code_pkg::*;
#(
    parameter bus_addr_t REG_ADDR = '0
) (
    input  logic                clk,
    input  logic                rst,
    input  fault_rec_t          idat,
    input  logic                ienb,
    fault_bus_if.target         bus,
    output bus_data_t           rdat,
    output logic                rvld,
    output logic                held
);

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    fault_rec_t rec_q;
    logic       held_q;
    logic       sel;
    logic       clear;
    logic       capture;

    // Address hit for both reads and writes
    assign sel = (bus.addr == REG_ADDR);

    // Only the clear code at our own address releases the record
    assign clear = bus.wren && sel && (bus.wdat == `FLT_CLR_CODE);

    // First strobe wins, later ones dropped while held
    assign capture = ienb && !held_q;

    //////////////////////////////////////////////////
    // Record and held flag
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            rec_q  <= '0;
            held_q <= 1'b0;
        end else if (capture) begin
            rec_q  <= idat;
            held_q <= 1'b1;
        end
    end

    // Zero-latency read, zero when not addressed
    assign rvld = bus.rden && sel;
    assign rdat = rvld ? bus_data_t'(rec_q) : '0;

    assign held = held_q;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the fault capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_fault_capture_sim

verilator --binary --timing -Wno-fatal -f fault_capture.f \
    --top-module tb_fault_capture -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* tb/tb_fault_capture.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fault_defs.svh"

module tb_fault_capture
    import fault_bus_pkg::*;
    import fault_code_pkg::*;
();

    logic       clk;
    logic       rst;
    logic       s_valid;
    seq_num_t   s_seq;
    payload_t   s_data;
    logic       s_par;
    logic       ext_err;
    fault_rec_t ext_rec;
    bus_addr_t  ps_addr;
    logic       ps_wren;
    bus_data_t  ps_wdat;
    logic       ps_rden;
    bus_data_t  ps_rdat;
    logic       ps_rvld;
    logic       irq;

    integer     seed = 32'hcea8;
    int         checks = 0;
    int         errors = 0;
    int         timeouts = 0;
    // Next in-order number the stream will carry
    seq_num_t   next_seq;
    fault_rec_t rec_a;
    fault_rec_t rec_b;
    payload_t   pay;

    fault_capture_top dut0 (
        .clk(clk), .rst(rst),
        .s_valid(s_valid), .s_seq(s_seq), .s_data(s_data), .s_par(s_par),
        .ext_err(ext_err), .ext_rec(ext_rec),
        .ps_addr(ps_addr), .ps_wren(ps_wren), .ps_wdat(ps_wdat), .ps_rden(ps_rden),
        .ps_rdat(ps_rdat), .ps_rvld(ps_rvld), .irq(irq)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Expected values from the record layout
    //////////////////////////////////////////////////

    // Expected number high, received number low
    function automatic fault_rec_t seq_record(seq_num_t exp_n, seq_num_t rcv_n);
        return {exp_n, rcv_n};
    endfunction

    // Seq high, payload low
    function automatic fault_rec_t parity_record(seq_num_t sq, payload_t pl);
        return {sq, pl};
    endfunction

    // Bit that makes the XOR over the word zero
    function automatic logic even_parity(seq_num_t sq, payload_t pl);
        return ^{sq, pl};
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_data(string name, bus_data_t got, bus_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_rec(string name, fault_rec_t got, fault_rec_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // Bus and stream drivers
    //////////////////////////////////////////////////

    task automatic bus_write(bus_addr_t a, bus_data_t d);
        @(posedge clk);
        ps_wren <= 1'b1;
        ps_addr <= a;
        ps_wdat <= d;
        @(posedge clk);
        ps_wren <= 1'b0;
    endtask

    // Zero-latency return, sampled mid-cycle
    task automatic bus_read(bus_addr_t a, output bus_data_t d, output logic v);
        @(posedge clk);
        ps_rden <= 1'b1;
        ps_addr <= a;
        @(negedge clk);
        d = ps_rdat;
        v = ps_rvld;
        @(posedge clk);
        ps_rden <= 1'b0;
    endtask

    task automatic expect_read(bus_addr_t a, bus_data_t exp, logic exp_vld);
        bus_data_t d;
        logic      v;
        bus_read(a, d, v);
        check_data($sformatf("ps_rdat@%h", a), d, exp);
        check_bit($sformatf("ps_rvld@%h", a), v, exp_vld);
    endtask

    task automatic expect_rec(bus_addr_t a, fault_rec_t exp);
        bus_data_t d;
        logic      v;
        bus_read(a, d, v);
        check_rec($sformatf("record@%h", a), fault_rec_t'(d), exp);
        check_bit($sformatf("ps_rvld@%h", a), v, 1'b1);
    endtask

    task automatic check_irq(logic exp);
        @(negedge clk);
        check_bit("irq", irq, exp);
    endtask

    // Flip the parity bit on request
    task automatic send_word(seq_num_t sq, payload_t pl, logic bad_par);
        @(posedge clk);
        s_valid <= 1'b1;
        s_seq   <= sq;
        s_data  <= pl;
        s_par   <= even_parity(sq, pl) ^ bad_par;
        @(posedge clk);
        s_valid <= 1'b0;
    endtask

    task automatic pulse_ext(fault_rec_t r);
        @(posedge clk);
        ext_err <= 1'b1;
        ext_rec <= r;
        @(posedge clk);
        ext_err <= 1'b0;
    endtask

    task automatic idle_cycles(int n);
        repeat (n) @(posedge clk);
    endtask

    // Poll the status register until one held bit reaches a level
    task automatic wait_held(int idx, logic level, int limit);
        bus_data_t d;
        logic      v;
        int        n;
        logic      done;
        n = 0;
        done = 1'b0;
        while (!done && n < limit) begin
            bus_read(`FLT_ADDR_STAT, d, v);
            if (d[idx] === level) done = 1'b1;
            n++;
        end
        if (!done) begin
            timeouts++;
            $display("Timeout: status bit %0d did not reach %b", idx, level);
        end
    endtask

    task automatic wait_irq(logic level, int limit);
        int n;
        n = 0;
        while (irq !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (irq !== level) begin
            timeouts++;
            $display("Timeout: irq did not reach %b", level);
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic test_reset_state();
        expect_read(`FLT_ADDR_SEQ, '0, 1'b1);
        expect_read(`FLT_ADDR_PAR, '0, 1'b1);
        expect_read(`FLT_ADDR_EXT, '0, 1'b1);
        expect_read(`FLT_ADDR_STAT, '0, 1'b1);
        // Unmapped
        expect_read(8'h10, '0, 1'b0);
        check_irq(1'b0);
    endtask

    task automatic test_clean_run();
        next_seq = seq_num_t'($random(seed));
        repeat (8) begin
            send_word(next_seq, payload_t'($random(seed)), 1'b0);
            next_seq = next_seq + 16'd1;
        end
        idle_cycles(2);
        expect_read(`FLT_ADDR_STAT, '0, 1'b1);
        expect_rec(`FLT_ADDR_SEQ, '0);
        expect_rec(`FLT_ADDR_PAR, '0);
        check_irq(1'b0);
    endtask

    task automatic test_seq_gap();
        send_word(next_seq, payload_t'($random(seed)), 1'b0);
        next_seq = next_seq + 16'd1;
        // Skip one number
        rec_a = seq_record(next_seq, next_seq + 16'd1);
        send_word(next_seq + 16'd1, payload_t'($random(seed)), 1'b0);
        next_seq = next_seq + 16'd2;
        wait_held(0, 1'b1, 10);
        expect_rec(`FLT_ADDR_SEQ, rec_a);
        expect_read(`FLT_ADDR_STAT, 32'h1, 1'b1);
        check_irq(1'b1);
        // Second gap must not overwrite
        send_word(next_seq + 16'd3, payload_t'($random(seed)), 1'b0);
        next_seq = next_seq + 16'd4;
        idle_cycles(3);
        expect_rec(`FLT_ADDR_SEQ, rec_a);
    endtask

    task automatic test_parity();
        bus_write(`FLT_ADDR_SEQ, `FLT_CLR_CODE);
        wait_held(0, 1'b0, 10);
        expect_rec(`FLT_ADDR_SEQ, '0);
        pay = payload_t'($random(seed));
        rec_a = parity_record(next_seq, pay);
        send_word(next_seq, pay, 1'b1);
        next_seq = next_seq + 16'd1;
        wait_held(1, 1'b1, 10);
        expect_rec(`FLT_ADDR_PAR, rec_a);
        // Checker still in step with the stream
        repeat (4) begin
            send_word(next_seq, payload_t'($random(seed)), 1'b0);
            next_seq = next_seq + 16'd1;
        end
        idle_cycles(3);
        expect_rec(`FLT_ADDR_SEQ, '0);
        expect_read(`FLT_ADDR_STAT, 32'h2, 1'b1);
    endtask

    task automatic test_ext_clear();
        rec_a = fault_rec_t'($random(seed));
        rec_b = ~rec_a;
        pulse_ext(rec_a);
        wait_held(2, 1'b1, 10);
        expect_rec(`FLT_ADDR_EXT, rec_a);
        pulse_ext(rec_b);
        idle_cycles(2);
        expect_rec(`FLT_ADDR_EXT, rec_a);
        // Wrong value, then clear code at the status address
        bus_write(`FLT_ADDR_EXT, 32'h2);
        expect_rec(`FLT_ADDR_EXT, rec_a);
        bus_write(`FLT_ADDR_STAT, `FLT_CLR_CODE);
        expect_rec(`FLT_ADDR_EXT, rec_a);
        expect_read(`FLT_ADDR_STAT, 32'h6, 1'b1);
        bus_write(`FLT_ADDR_EXT, `FLT_CLR_CODE);
        expect_rec(`FLT_ADDR_EXT, '0);
        expect_read(`FLT_ADDR_STAT, 32'h2, 1'b1);
    endtask

    task automatic test_rearm();
        pulse_ext(32'h0000_00a5);
        rec_a = seq_record(next_seq, next_seq + 16'd1);
        send_word(next_seq + 16'd1, payload_t'($random(seed)), 1'b0);
        next_seq = next_seq + 16'd2;
        wait_held(0, 1'b1, 10);
        expect_read(`FLT_ADDR_STAT, 32'h7, 1'b1);
        expect_rec(`FLT_ADDR_SEQ, rec_a);
        // irq stays up until the last one goes
        bus_write(`FLT_ADDR_SEQ, `FLT_CLR_CODE);
        check_irq(1'b1);
        bus_write(`FLT_ADDR_PAR, `FLT_CLR_CODE);
        check_irq(1'b1);
        bus_write(`FLT_ADDR_EXT, `FLT_CLR_CODE);
        wait_irq(1'b0, 4);
        expect_read(`FLT_ADDR_STAT, '0, 1'b1);
        pulse_ext(32'h0000_5a00);
        wait_held(2, 1'b1, 10);
        expect_rec(`FLT_ADDR_EXT, 32'h0000_5a00);
        wait_irq(1'b1, 4);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        rst     = 1'b1;
        s_valid = 1'b0;
        s_seq   = '0;
        s_data  = '0;
        s_par   = 1'b0;
        ext_err = 1'b0;
        ext_rec = '0;
        ps_addr = '0;
        ps_wren = 1'b0;
        ps_wdat = '0;
        ps_rden = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        test_reset_state();
        test_clean_run();
        test_seq_gap();
        test_parity();
        test_ext_clear();
        test_rearm();

        $display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
